// ==== Makefile ====
obj_dir/Vcore_issue_tb: tb.f $(wildcard logic/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
	verilator --binary --timing -Wno-fatal -f tb.f --top-module core_issue_tb -o Vcore_issue_tb

run: obj_dir/Vcore_issue_tb
	./obj_dir/Vcore_issue_tb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== logic/bundle_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module bundle_buffer (
   input  wire                     clkrst_core_clk,
   input  wire                     clkrst_core_rst_n,
   input  wire                     bundle_valid,
   input  wire core_pipe_pkg::bundle_t bundle_in,
   output logic                    head_valid,
   output core_pipe_pkg::bundle_t  head_bundle,
   input  wire                     head_pop,
   output logic                    credit_return
);

   typedef logic [core_pipe_pkg::buf_ptr_w-1:0] ptr_t;
   typedef logic [core_pipe_pkg::buf_cnt_w-1:0] cnt_t;

   core_pipe_pkg::bundle_t mem [core_pipe_pkg::buf_depth];
   ptr_t wr_ptr;
   ptr_t rd_ptr;
   cnt_t count;

   assign head_valid  = (count != '0);
   assign head_bundle = mem[rd_ptr];

   // credits upstream guarantee a free slot, so no full check here
   always_ff @(posedge clkrst_core_clk) begin
      if (bundle_valid)
         mem[wr_ptr] <= bundle_in;
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end else begin
         credit_return <= head_pop;   // one credit back per removed bundle

         if (bundle_valid)
            wr_ptr <= (wr_ptr == ptr_t'(core_pipe_pkg::buf_depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (head_pop)
            rd_ptr <= (rd_ptr == ptr_t'(core_pipe_pkg::buf_depth - 1)) ? '0 : rd_ptr + 1'b1;

         case ({bundle_valid, head_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/core_isa_pkg.sv ====
`default_nettype none

// architectural dimensions of the vliw core
package core_isa_pkg;

   localparam int num_lanes = 4;                  // issue slots per bundle
   localparam int num_gprs  = 32;
   localparam int gpr_idx_w = $clog2(num_gprs);

   localparam int num_preds  = 3;
   // predicate index comes from the low bits of rd_num, so index 3 maps to nothing
   localparam int pred_idx_w = 2;

   typedef logic [gpr_idx_w-1:0] reg_num_t;

   typedef logic [num_gprs-1:0]  gpr_mask_t;
   typedef logic [num_preds-1:0] pred_mask_t;

endpackage

`default_nettype wire

// ==== logic/core_issue_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_issue_top (
   input  wire                                  clkrst_core_clk,
   input  wire                                  clkrst_core_rst_n,
   input  wire                                  bundle_valid,
   input  wire core_pipe_pkg::bundle_t          bundle_in,
   input  wire                                  pipe_flush,
   output logic                                 credit_return,
   output logic                                 issue_fire,
   output logic [core_isa_pkg::num_gprs-1:0]    reg_busy,
   output logic [core_isa_pkg::num_preds-1:0]   pred_busy,
   output core_pipe_pkg::wb_lane_vec_t          wb_lanes,
   output logic                                 exception
);

   logic                   head_valid;
   logic                   head_pop;
   core_pipe_pkg::bundle_t head_bundle;

   issue_if issue_bus ();
   wb_if    wb_bus ();

   bundle_buffer u_buffer (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .bundle_valid      (bundle_valid),
      .bundle_in         (bundle_in),
      .head_valid        (head_valid),
      .head_bundle       (head_bundle),
      .head_pop          (head_pop),
      .credit_return     (credit_return)
   );

   issue_ctl u_issue (
      .head_valid  (head_valid),
      .head_bundle (head_bundle),
      .head_pop    (head_pop),
      .pipe_flush  (pipe_flush),
      .reg_busy    (reg_busy),
      .pred_busy   (pred_busy),
      .issue       (issue_bus.ctl),
      .issue_fire  (issue_fire)
   );

   core_scoreboard u_sb (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .issue             (issue_bus.sb),
      .wb                (wb_bus.sink),
      .reg_busy          (reg_busy),
      .pred_busy         (pred_busy)
   );

   exec_pipe u_pipe (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .issue             (issue_bus.pipe),
      .wb                (wb_bus.pipe)
   );

   assign wb_lanes  = wb_bus.lanes;
   assign exception = wb_bus.exception;

endmodule

`default_nettype wire

// ==== logic/core_pipe_pkg.sv ====
`default_nettype none

package core_pipe_pkg;

   typedef struct packed {
      core_isa_pkg::reg_num_t rd_num;
      logic                   rd_we;
      logic                   pred_we;   // pred index is rd_num[1:0]
      core_isa_pkg::reg_num_t src_a;
      core_isa_pkg::reg_num_t src_b;
   } lane_t;

   typedef lane_t [core_isa_pkg::num_lanes-1:0] lane_vec_t;

   typedef struct packed {
      lane_vec_t lanes;
      logic      fault;                    // raises exception one cycle after issue
   } bundle_t;

   typedef struct packed {
      core_isa_pkg::reg_num_t rd_num;
      logic                   rd_we;
      logic                   pred_we;
   } wb_lane_t;

   typedef wb_lane_t [core_isa_pkg::num_lanes-1:0] wb_lane_vec_t;

   localparam int exec_lat  = 4;           // issue to writeback, in cycles
   localparam int buf_depth = 4;           // equals the credits held upstream
   localparam int buf_ptr_w = $clog2(buf_depth);
   localparam int buf_cnt_w = $clog2(buf_depth + 1);

endpackage

`default_nettype wire

// ==== logic/core_scoreboard.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_scoreboard (
   input  wire                                  clkrst_core_clk,
   input  wire                                  clkrst_core_rst_n,
   issue_if.sb                                  issue,
   wb_if.sink                                   wb,
   output logic [core_isa_pkg::num_gprs-1:0]    reg_busy,
   output logic [core_isa_pkg::num_preds-1:0]   pred_busy
);

   typedef core_isa_pkg::gpr_mask_t  gpr_mask_t;
   typedef core_isa_pkg::pred_mask_t pred_mask_t;

   // one-hot destinations of the last issued bundle
   gpr_mask_t  dcd_reg1h  [core_isa_pkg::num_lanes];
   pred_mask_t dcd_pred1h [core_isa_pkg::num_lanes];
   logic [core_isa_pkg::num_lanes-1:0] dcd_regval;
   logic [core_isa_pkg::num_lanes-1:0] dcd_predval;

   // one-cleared masks of the last writeback
   gpr_mask_t  wb_reg1c  [core_isa_pkg::num_lanes];
   pred_mask_t wb_pred1c [core_isa_pkg::num_lanes];
   logic [core_isa_pkg::num_lanes-1:0] wb_regval;
   logic [core_isa_pkg::num_lanes-1:0] wb_predval;

   gpr_mask_t  prev_reg_busy;
   pred_mask_t prev_pred_busy;

   gpr_mask_t  new_reg_field;
   gpr_mask_t  old_reg_field;
   pred_mask_t new_pred_field;
   pred_mask_t old_pred_field;

   always_comb begin
      new_reg_field  = '0;
      old_reg_field  = '1;
      new_pred_field = '0;
      old_pred_field = '1;
      for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
         new_reg_field  |= dcd_reg1h[l] & {core_isa_pkg::num_gprs{dcd_regval[l]}};
         old_reg_field  &= wb_reg1c[l] | {core_isa_pkg::num_gprs{~wb_regval[l]}};
         new_pred_field |= dcd_pred1h[l] & {core_isa_pkg::num_preds{dcd_predval[l]}};
         old_pred_field &= wb_pred1c[l] | {core_isa_pkg::num_preds{~wb_predval[l]}};
      end
   end

   assign reg_busy  = (prev_reg_busy | new_reg_field) & old_reg_field;
   assign pred_busy = (prev_pred_busy | new_pred_field) & old_pred_field;

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
            dcd_reg1h[l]  <= '0;
            dcd_pred1h[l] <= '0;
            wb_reg1c[l]   <= '0;
            wb_pred1c[l]  <= '0;
         end
         dcd_regval     <= '0;
         dcd_predval    <= '0;
         wb_regval      <= '0;
         wb_predval     <= '0;
         prev_reg_busy  <= '0;
         prev_pred_busy <= '0;
      end else begin
         for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
            wb_reg1c[l]  <= ~(gpr_mask_t'(1) << wb.lanes[l].rd_num);
            wb_pred1c[l] <= ~(pred_mask_t'(1) <<
                              wb.lanes[l].rd_num[core_isa_pkg::pred_idx_w-1:0]);
            wb_regval[l]  <= wb.lanes[l].rd_we;
            wb_predval[l] <= wb.lanes[l].pred_we;

            dcd_reg1h[l]  <= gpr_mask_t'(1) << issue.lanes[l].rd_num;
            dcd_pred1h[l] <= pred_mask_t'(1) <<
                             issue.lanes[l].rd_num[core_isa_pkg::pred_idx_w-1:0];
            dcd_regval[l]  <= issue.progress && issue.lanes[l].rd_we;
            dcd_predval[l] <= issue.progress && issue.lanes[l].pred_we;
         end

         // exception lands while new_*_field still holds the faulting bundle
         prev_reg_busy  <= reg_busy & ~(new_reg_field & {core_isa_pkg::num_gprs{wb.exception}});
         prev_pred_busy <= pred_busy &
                           ~(new_pred_field & {core_isa_pkg::num_preds{wb.exception}});
      end
   end

endmodule

`default_nettype wire

// ==== logic/exec_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_pipe (
   input  wire   clkrst_core_clk,
   input  wire   clkrst_core_rst_n,
   issue_if.pipe issue,
   wb_if.pipe    wb
);

   localparam int last = core_pipe_pkg::exec_lat - 1;

   core_pipe_pkg::wb_lane_vec_t      st_lanes [core_pipe_pkg::exec_lat];
   logic [core_pipe_pkg::exec_lat-1:0] st_valid;
   logic                             st_fault;   // fault flag of stage 0 only
   core_pipe_pkg::wb_lane_vec_t      wb_out;

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         st_valid <= '0;
         st_fault <= 1'b0;
      end else begin
         st_fault <= issue.fault;
         // a faulting bundle does not leave stage 0
         st_valid <= {st_valid[last-1:1], st_valid[0] && !st_fault, issue.progress};
      end
   end

   always_ff @(posedge clkrst_core_clk) begin
      for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
         st_lanes[0][l].rd_num  <= issue.lanes[l].rd_num;
         st_lanes[0][l].rd_we   <= issue.lanes[l].rd_we;
         st_lanes[0][l].pred_we <= issue.lanes[l].pred_we;

         st_lanes[1][l].rd_num  <= st_lanes[0][l].rd_num;
         st_lanes[1][l].rd_we   <= st_lanes[0][l].rd_we && !st_fault;
         st_lanes[1][l].pred_we <= st_lanes[0][l].pred_we && !st_fault;
      end
      for (int s = 2; s < core_pipe_pkg::exec_lat; s++)
         st_lanes[s] <= st_lanes[s-1];
   end

   always_comb begin
      wb_out = st_lanes[last];
      for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
         wb_out[l].rd_we   = st_lanes[last][l].rd_we && st_valid[last];
         wb_out[l].pred_we = st_lanes[last][l].pred_we && st_valid[last];
      end
   end

   assign wb.lanes     = wb_out;
   assign wb.exception = st_valid[0] && st_fault;   // cycle after issue

endmodule

`default_nettype wire

// ==== logic/issue_ctl.sv ====
`timescale 1ns/1ns
`default_nettype none

// purely combinational: the head is checked against the masks in the cycle it shows up
module issue_ctl (
   input  wire                                  head_valid,
   input  wire core_pipe_pkg::bundle_t          head_bundle,
   output logic                                 head_pop,
   input  wire                                  pipe_flush,
   input  wire [core_isa_pkg::num_gprs-1:0]     reg_busy,
   input  wire [core_isa_pkg::num_preds-1:0]    pred_busy,
   issue_if.ctl                                 issue,
   output logic                                 issue_fire
);

   logic                     hazard;
   core_pipe_pkg::lane_vec_t out_lanes;

   // a lane takes part only when it writes something
   always_comb begin
      core_pipe_pkg::lane_t      ln;
      core_isa_pkg::pred_mask_t  pred_1h;
      hazard = 1'b0;
      for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
         ln      = head_bundle.lanes[l];
         pred_1h = core_isa_pkg::pred_mask_t'(1) << ln.rd_num[core_isa_pkg::pred_idx_w-1:0];
         if (ln.rd_we || ln.pred_we) begin
            if (reg_busy[ln.src_a] || reg_busy[ln.src_b])
               hazard = 1'b1;
            if (ln.rd_we && reg_busy[ln.rd_num])
               hazard = 1'b1;   // waw on a gpr
            if (ln.pred_we && |(pred_1h & pred_busy))
               hazard = 1'b1;
         end
      end
   end

   assign issue_fire = head_valid && !pipe_flush && !hazard;
   assign head_pop   = issue_fire || (head_valid && pipe_flush);   // flush drops the head

   always_comb begin
      out_lanes = head_bundle.lanes;
      for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
         out_lanes[l].rd_we   = head_bundle.lanes[l].rd_we && !pipe_flush;
         out_lanes[l].pred_we = head_bundle.lanes[l].pred_we && !pipe_flush;
      end
   end

   assign issue.progress = issue_fire;
   assign issue.lanes    = out_lanes;
   assign issue.fault    = head_bundle.fault;

endmodule

`default_nettype wire

// ==== logic/issue_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// issued bundle, from the issue controller to scoreboard and exec pipe
interface issue_if ();

   logic                     progress;   // a bundle issues this cycle
   core_pipe_pkg::lane_vec_t lanes;      // write enables already cleared on flush
   logic                     fault;

   modport ctl (
      output progress,
      output lanes,
      output fault
   );

   // only destinations matter for busy tracking
   modport sb (
      input progress,
      input lanes
   );

   modport pipe (
      input progress,
      input lanes,
      input fault
   );

endinterface

`default_nettype wire

// ==== logic/wb_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface wb_if ();

   core_pipe_pkg::wb_lane_vec_t lanes;
   logic                        exception;

   modport pipe (
      output lanes,
      output exception
   );

   modport sink (
      input lanes,
      input exception
   );

endinterface

`default_nettype wire

// ==== tb.f ====
+incdir+test
logic/core_isa_pkg.sv
logic/core_pipe_pkg.sv
logic/issue_if.sv
logic/wb_if.sv
logic/bundle_buffer.sv
logic/issue_ctl.sv
logic/core_scoreboard.sv
logic/exec_pipe.sv
logic/core_issue_top.sv
test/core_issue_tb.sv

// ==== test/issue_model.svh ====
`ifndef issue_model_svh
`define issue_model_svh

// expected state of the issue slice, future events kept in per-cycle ring slots
localparam int ring_len = 16;

core_pipe_pkg::bundle_t      sent_q [$];   // bundles in the buffer, oldest first
int                          credits;
core_isa_pkg::gpr_mask_t     m_reg;
core_isa_pkg::pred_mask_t    m_pred;
core_isa_pkg::gpr_mask_t     set_reg  [ring_len];
core_isa_pkg::gpr_mask_t     clr_reg  [ring_len];
core_isa_pkg::pred_mask_t    set_pred [ring_len];
core_isa_pkg::pred_mask_t    clr_pred [ring_len];
logic                        wb_due   [ring_len];
logic                        exc_due  [ring_len];
core_pipe_pkg::wb_lane_vec_t wb_slot  [ring_len];

task automatic reset_model();
   sent_q.delete();
   credits = core_pipe_pkg::buf_depth;
   m_reg   = '0;
   m_pred  = '0;
   for (int i = 0; i < ring_len; i++) begin
      set_reg[i]  = '0;
      clr_reg[i]  = '0;
      set_pred[i] = '0;
      clr_pred[i] = '0;
      wb_due[i]   = 1'b0;
      exc_due[i]  = 1'b0;
      wb_slot[i]  = '0;
   end
endtask

function automatic core_isa_pkg::gpr_mask_t reg_dest_mask(input core_pipe_pkg::bundle_t b);
   core_isa_pkg::gpr_mask_t m;
   m = '0;
   for (int l = 0; l < core_isa_pkg::num_lanes; l++)
      if (b.lanes[l].rd_we)
         m[b.lanes[l].rd_num] = 1'b1;
   return m;
endfunction

function automatic core_isa_pkg::pred_mask_t pred_dest_mask(input core_pipe_pkg::bundle_t b);
   core_isa_pkg::pred_mask_t m;
   int idx;
   m = '0;
   for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
      idx = int'(b.lanes[l].rd_num[1:0]);   // index 3 names no predicate
      if (b.lanes[l].pred_we && idx < core_isa_pkg::num_preds)
         m[idx] = 1'b1;
   end
   return m;
endfunction

function automatic logic has_hazard(input core_pipe_pkg::bundle_t b);
   core_pipe_pkg::lane_t ln;
   logic hz;
   hz = |(reg_dest_mask(b) & m_reg) || |(pred_dest_mask(b) & m_pred);
   for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
      ln = b.lanes[l];
      if ((ln.rd_we || ln.pred_we) && (m_reg[ln.src_a] || m_reg[ln.src_b]))
         hz = 1'b1;
   end
   return hz;
endfunction

// busy from c+1, gone after the writeback or right after the exception
task automatic schedule_issue(input core_pipe_pkg::bundle_t b, input int c);
   int done_at;
   int wb_at;
   done_at = b.fault ? c + 2 : c + core_pipe_pkg::exec_lat + 1;
   wb_at   = (c + core_pipe_pkg::exec_lat) % ring_len;
   set_reg[(c + 1) % ring_len]  |= reg_dest_mask(b);
   set_pred[(c + 1) % ring_len] |= pred_dest_mask(b);
   clr_reg[done_at % ring_len]  |= reg_dest_mask(b);
   clr_pred[done_at % ring_len] |= pred_dest_mask(b);
   exc_due[(c + 1) % ring_len]   = b.fault;
   if (!b.fault) begin
      wb_due[wb_at] = 1'b1;
      for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
         wb_slot[wb_at][l].rd_num  = b.lanes[l].rd_num;
         wb_slot[wb_at][l].rd_we   = b.lanes[l].rd_we;
         wb_slot[wb_at][l].pred_we = b.lanes[l].pred_we;
      end
   end
endtask

task automatic advance_masks(input int c);
   int n;
   n = (c + 1) % ring_len;
   m_reg           = (m_reg | set_reg[n]) & ~clr_reg[n];
   m_pred          = (m_pred | set_pred[n]) & ~clr_pred[n];
   set_reg[n]      = '0;
   clr_reg[n]      = '0;
   set_pred[n]     = '0;
   clr_pred[n]     = '0;
   wb_due[c % ring_len]  = 1'b0;   // this cycle's slots are used up
   exc_due[c % ring_len] = 1'b0;
endtask

`endif

// ==== test/core_issue_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_issue_tb;

   localparam int num_bundles    = 400;
   localparam int timeout_cycles = num_bundles * (core_pipe_pkg::exec_lat + 8);

   logic                        clkrst_core_clk = 1'b0;
   logic                        clkrst_core_rst_n;
   logic                        bundle_valid;
   core_pipe_pkg::bundle_t      bundle_in;
   logic                        pipe_flush;
   logic                        credit_return;
   logic                        issue_fire;
   core_isa_pkg::gpr_mask_t     reg_busy;
   core_isa_pkg::pred_mask_t    pred_busy;
   core_pipe_pkg::wb_lane_vec_t wb_lanes;
   logic                        exception;

   int   cycle_count    = 0;
   int   mismatch_count = 0;
   int   other_count    = 0;
   int   sent_total     = 0;
   logic sent_now;
   logic popped_last;   // head left the buffer last cycle

   `include "issue_model.svh"

   core_issue_top dut_i (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .bundle_valid      (bundle_valid),
      .bundle_in         (bundle_in),
      .pipe_flush        (pipe_flush),
      .credit_return     (credit_return),
      .issue_fire        (issue_fire),
      .reg_busy          (reg_busy),
      .pred_busy         (pred_busy),
      .wb_lanes          (wb_lanes),
      .exception         (exception)
   );

   always #10 clkrst_core_clk = ~clkrst_core_clk;

   always @(posedge clkrst_core_clk) cycle_count++;

   task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                  input logic [31:0] got_v);
      $display("MISMATCH %s cycle %0d: expected %0h got %0h", sig, cycle_count, exp_v, got_v);
      mismatch_count++;
   endtask

   task automatic report_error(input string msg);
      $display("ERROR cycle %0d: %s", cycle_count, msg);
      other_count++;
   endtask

   function automatic core_pipe_pkg::bundle_t random_bundle();
      core_pipe_pkg::bundle_t b;
      for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
         b.lanes[l].rd_num  = core_isa_pkg::reg_num_t'($urandom % 8);   // r0..r7 only
         b.lanes[l].rd_we   = ($urandom % 4) != 0;
         b.lanes[l].pred_we = ($urandom % 4) == 0;
         b.lanes[l].src_a   = core_isa_pkg::reg_num_t'($urandom % 8);
         b.lanes[l].src_b   = core_isa_pkg::reg_num_t'($urandom % 8);
      end
      b.fault = ($urandom % 16) == 0;
      return b;
   endfunction

   task automatic drive_inputs();
      pipe_flush   = ($urandom % 20) == 0;
      sent_now     = sent_total < num_bundles && credits > 0 && ($urandom % 4) != 0;
      bundle_valid = sent_now;
      bundle_in    = sent_now ? random_bundle() : '0;
      if (sent_now) begin
         credits--;
         sent_total++;
      end
   endtask

   task automatic check_cycle();
      int   idx;
      logic exp_fire;
      logic popped;
      idx = cycle_count % ring_len;
      if (credit_return) begin
         credits++;
         if (credits > core_pipe_pkg::buf_depth)
            report_error("upstream credit count rose above the buffer depth");
      end
      if (credit_return !== popped_last)
         report_mismatch("credit_return", popped_last, credit_return);
      exp_fire = sent_q.size() > 0 && !pipe_flush && !has_hazard(sent_q[0]);
      if (issue_fire !== exp_fire)
         report_mismatch("issue_fire", exp_fire, issue_fire);
      if (reg_busy !== m_reg)
         report_mismatch("reg_busy", m_reg, reg_busy);
      if (pred_busy !== m_pred)
         report_mismatch("pred_busy", m_pred, pred_busy);
      if (exception !== exc_due[idx])
         report_mismatch("exception", exc_due[idx], exception);
      for (int l = 0; l < core_isa_pkg::num_lanes; l++) begin
         if (wb_due[idx] && wb_lanes[l] !== wb_slot[idx][l])
            report_mismatch($sformatf("wb_lanes[%0d]", l), wb_slot[idx][l], wb_lanes[l]);
         if (!wb_due[idx] && {wb_lanes[l].rd_we, wb_lanes[l].pred_we} !== 2'b00)
            report_mismatch($sformatf("wb_lanes[%0d] enables", l), 0,
                            {wb_lanes[l].rd_we, wb_lanes[l].pred_we});
      end

      // move the model on to the next cycle
      popped = sent_q.size() > 0 && (pipe_flush || exp_fire);
      if (exp_fire)
         schedule_issue(sent_q[0], cycle_count);
      if (popped)
         void'(sent_q.pop_front());   // flushed heads are simply dropped
      popped_last = popped;
      if (sent_now)
         sent_q.push_back(bundle_in);
      advance_masks(cycle_count);
   endtask

   initial begin
      int idle;
      void'($urandom(32'h5e47));
      clkrst_core_rst_n = 1'b0;
      bundle_valid      = 1'b0;
      bundle_in         = '0;
      pipe_flush        = 1'b0;
      sent_now          = 1'b0;
      popped_last       = 1'b0;
      idle              = 0;
      reset_model();
      repeat (2) @(posedge clkrst_core_clk);
      #2;
      clkrst_core_rst_n = 1'b1;

      // run until every bundle is sent and the pipe has drained
      while (idle < core_pipe_pkg::exec_lat + 4) begin
         drive_inputs();
         @(negedge clkrst_core_clk);
         check_cycle();
         if (sent_total == num_bundles && sent_q.size() == 0)
            idle++;
         @(posedge clkrst_core_clk);
         #2;
      end

      if (credits != core_pipe_pkg::buf_depth)
         report_error("not every credit came back after the drain");
      $display("finished after %0d cycles: %0d mismatches, %0d other errors",
               cycle_count, mismatch_count, other_count);
      if (mismatch_count + other_count == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      wait (cycle_count >= timeout_cycles);
      $display("timeout: the run did not drain within %0d cycles", timeout_cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
